//--- design/uart_pkg.sv
package uart_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [1:0] reg_addr_t;
    typedef logic [7:0] bus_word_t;
    typedef logic [3:0] baud_cnt_t;
    typedef logic [3:0] bit_idx_t;

    localparam int BIT_CYCLES = 8;   // clk_uart cycles per bit.
    localparam int FRAME_BITS = 10;  // start, 8 data, stop.

    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT  = 1'b1;

    localparam reg_addr_t ADDR_TXDATA = 2'd0;
    localparam reg_addr_t ADDR_RXDATA = 2'd1;
    localparam reg_addr_t ADDR_STATUS = 2'd2;

    // status register bit positions
    localparam int STATUS_TX_IDLE    = 0;
    localparam int STATUS_RX_FULL    = 1;
    localparam int STATUS_RX_OVERRUN = 2;
    localparam int STATUS_FRAME_ERR  = 3;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_WAIT
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACK,
        BUS_RELEASE
    } bus_state_t;

endpackage

//--- design/flag_sync.sv
`timescale 1ns/1ps

module flag_sync (
    input  logic clk_src,
    input  logic rst_src_n,
    input  logic flag_src,
    input  logic clk_dst,
    input  logic rst_dst_n,
    output logic flag_dst
);

    logic       toggle_src;
    logic [2:0] sync_dst;

    // each source pulse flips the level.
    always_ff @(posedge clk_src or negedge rst_src_n) begin
        if (!rst_src_n) begin
            toggle_src <= 1'b0;
        end else if (flag_src) begin
            toggle_src <= ~toggle_src;
        end
    end

    // two sync stages plus one for the edge.
    always_ff @(posedge clk_dst or negedge rst_dst_n) begin
        if (!rst_dst_n) begin
            sync_dst <= 3'b000;
        end else begin
            sync_dst <= {sync_dst[1:0], toggle_src};
        end
    end

    // any change of the level is one pulse.
    assign flag_dst = sync_dst[2] ^ sync_dst[1];

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic  clk_bus,
    input  logic  clk_uart,
    input  logic  rst_n,
    input  logic  rst_uart_n,
    input  logic  tx_start,
    input  byte_t tx_data,
    output logic  tx_idle,
    output logic  txd
);

    logic                  tx_req_bus;
    logic                  tx_req_uart;
    logic                  tx_done_uart;
    logic                  tx_done_bus;
    byte_t                 data_bus;
    byte_t                 data_sync [2];
    logic [FRAME_BITS-1:0] send_buf;
    tx_state_t             state;
    bit_idx_t              bit_idx;
    baud_cnt_t             baud_cnt;

    flag_sync u_sync_req (
        .clk_src   (clk_bus),
        .rst_src_n (rst_n),
        .flag_src  (tx_req_bus),
        .clk_dst   (clk_uart),
        .rst_dst_n (rst_uart_n),
        .flag_dst  (tx_req_uart)
    );

    flag_sync u_sync_done (
        .clk_src   (clk_uart),
        .rst_src_n (rst_uart_n),
        .flag_src  (tx_done_uart),
        .clk_dst   (clk_bus),
        .rst_dst_n (rst_n),
        .flag_dst  (tx_done_bus)
    );

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            tx_idle    <= 1'b1;
            tx_req_bus <= 1'b0;
        end else begin
            tx_req_bus <= 1'b0;
            if (tx_start && tx_idle) begin
                tx_req_bus <= 1'b1;
                tx_idle    <= 1'b0;
            end else if (tx_done_bus) begin
                tx_idle <= 1'b1;  // frame fully sent.
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (tx_start && tx_idle) begin
            data_bus <= tx_data;
        end
    end

    // byte settles here before the request pulse arrives.
    always_ff @(posedge clk_uart) begin
        data_sync[0] <= data_bus;
        data_sync[1] <= data_sync[0];
    end

    always_ff @(posedge clk_uart or negedge rst_uart_n) begin
        if (!rst_uart_n) begin
            state        <= TX_IDLE;
            txd          <= STOP_BIT;
            tx_done_uart <= 1'b0;
            send_buf     <= '1;
            bit_idx      <= '0;
            baud_cnt     <= '0;
        end else begin
            tx_done_uart <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (tx_req_uart) begin
                        send_buf <= {STOP_BIT, data_sync[1], START_BIT};
                        bit_idx  <= '0;
                        state    <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    txd      <= send_buf[0];  // lsb first.
                    send_buf <= {STOP_BIT, send_buf[FRAME_BITS-1:1]};
                    baud_cnt <= baud_cnt_t'(BIT_CYCLES - 1);
                    state    <= TX_WAIT;
                end
                TX_WAIT: begin
                    if (baud_cnt == baud_cnt_t'(1)) begin
                        if (bit_idx == bit_idx_t'(FRAME_BITS - 1)) begin
                            tx_done_uart <= 1'b1;  // stop bit done.
                            state        <= TX_IDLE;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            state   <= TX_SHIFT;
                        end
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic  clk_bus,
    input  logic  clk_uart,
    input  logic  rst_n,
    input  logic  rst_uart_n,
    input  logic  rxd,
    output logic  rx_valid,
    output byte_t rx_data,
    output logic  rx_frame_err
);

    logic      rxd_meta;
    logic      rxd_sync;
    logic      rxd_prev;
    logic      start_edge;
    rx_state_t state;
    baud_cnt_t baud_cnt;
    bit_idx_t  bit_idx;
    byte_t     shift_reg;
    byte_t     byte_uart;
    logic      err_uart;
    logic      done_uart;
    logic      done_bus;

    flag_sync u_sync_done (
        .clk_src   (clk_uart),
        .rst_src_n (rst_uart_n),
        .flag_src  (done_uart),
        .clk_dst   (clk_bus),
        .rst_dst_n (rst_n),
        .flag_dst  (done_bus)
    );

    always_ff @(posedge clk_uart or negedge rst_uart_n) begin
        if (!rst_uart_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign start_edge = rxd_prev && !rxd_sync;

    always_ff @(posedge clk_uart or negedge rst_uart_n) begin
        if (!rst_uart_n) begin
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            shift_reg <= '0;
            byte_uart <= '0;
            err_uart  <= 1'b0;
            done_uart <= 1'b0;
        end else begin
            done_uart <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (start_edge) begin
                        baud_cnt <= baud_cnt_t'(BIT_CYCLES / 2 - 1);  // half a bit.
                        state    <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else if (rxd_sync == START_BIT) begin
                        baud_cnt <= baud_cnt_t'(BIT_CYCLES - 1);
                        bit_idx  <= '0;
                        state    <= RX_DATA;
                    end else begin
                        state <= RX_IDLE;  // glitch, not a start.
                    end
                end
                RX_DATA: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        shift_reg <= {rxd_sync, shift_reg[7:1]};
                        baud_cnt  <= baud_cnt_t'(BIT_CYCLES - 1);
                        if (bit_idx == bit_idx_t'($bits(byte_t) - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        byte_uart <= shift_reg;
                        err_uart  <= (rxd_sync != STOP_BIT);
                        done_uart <= 1'b1;
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= done_bus;
        end
    end

    // uart side holds these until the next frame ends.
    always_ff @(posedge clk_bus) begin
        if (done_bus) begin
            rx_data      <= byte_uart;
            rx_frame_err <= err_uart;
        end
    end

endmodule

//--- design/uart_regs.sv
`timescale 1ns/1ps

module uart_regs import uart_pkg::*; (
    input  logic      clk_bus,
    input  logic      rst_n,
    input  logic      req,
    input  logic      we,
    input  reg_addr_t addr,
    input  bus_word_t wdata,
    output bus_word_t rdata,
    output logic      ack,
    output logic      tx_start,
    output byte_t     tx_data,
    input  logic      tx_idle,
    input  logic      rx_valid,
    input  byte_t     rx_data,
    input  logic      rx_frame_err
);

    bus_state_t state;
    logic       tx_wr;
    logic       access;
    logic       rd_rxdata;
    logic       wr_status;
    byte_t      rx_byte;
    logic       rx_full;
    logic       rx_overrun;
    logic       frame_err;
    bus_word_t  status_word;
    bus_word_t  rd_word;

    assign tx_wr     = req && we && (addr == ADDR_TXDATA);
    assign access    = (state == BUS_IDLE) && req && (!tx_wr || tx_idle);  // waits on busy tx.
    assign rd_rxdata = access && !we && (addr == ADDR_RXDATA);
    assign wr_status = access && we && (addr == ADDR_STATUS);

    always_comb begin
        status_word                    = '0;
        status_word[STATUS_TX_IDLE]    = tx_idle;
        status_word[STATUS_RX_FULL]    = rx_full;
        status_word[STATUS_RX_OVERRUN] = rx_overrun;
        status_word[STATUS_FRAME_ERR]  = frame_err;
    end

    always_comb begin
        case (addr)
            ADDR_RXDATA: rd_word = rx_byte;
            ADDR_STATUS: rd_word = status_word;
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BUS_IDLE;
            ack      <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= access && tx_wr;  // same cycle as ack.
            case (state)
                BUS_IDLE: begin
                    if (access) begin
                        ack   <= 1'b1;
                        state <= BUS_ACK;
                    end
                end
                BUS_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= BUS_RELEASE;
                    end
                end
                BUS_RELEASE: state <= BUS_IDLE;
                default:     state <= BUS_IDLE;
            endcase
        end
    end

    // clears first so a new event in the same cycle wins.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rx_full    <= 1'b0;
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            if (rd_rxdata) begin
                rx_full <= 1'b0;
            end
            if (wr_status && wdata[STATUS_RX_OVERRUN]) begin
                rx_overrun <= 1'b0;
            end
            if (wr_status && wdata[STATUS_FRAME_ERR]) begin
                frame_err <= 1'b0;
            end
            if (rx_valid) begin
                rx_full <= 1'b1;
                if (rx_full && !rd_rxdata) begin
                    rx_overrun <= 1'b1;  // old byte lost.
                end
                if (rx_frame_err) begin
                    frame_err <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (access && tx_wr) begin
            tx_data <= wdata;
        end
        if (access && !we) begin
            rdata <= rd_word;
        end
        if (rx_valid) begin
            rx_byte <= rx_data;
        end
    end

endmodule

//--- design/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
    input  logic      clk_bus,
    input  logic      clk_uart,
    input  logic      rst_n,
    input  logic      rst_uart_n,
    input  logic      req,
    input  logic      we,
    input  reg_addr_t addr,
    input  bus_word_t wdata,
    output bus_word_t rdata,
    output logic      ack,
    output logic      txd,
    input  logic      rxd
);

    logic  tx_start;
    byte_t tx_data;
    logic  tx_idle;
    logic  rx_valid;
    byte_t rx_data;
    logic  rx_frame_err;

    uart_regs u_regs (
        .clk_bus      (clk_bus),
        .rst_n        (rst_n),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .ack          (ack),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .tx_idle      (tx_idle),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err)
    );

    uart_tx u_tx (
        .clk_bus    (clk_bus),
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .rst_uart_n (rst_uart_n),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .tx_idle    (tx_idle),
        .txd        (txd)
    );

    uart_rx u_rx (
        .clk_bus      (clk_bus),
        .clk_uart     (clk_uart),
        .rst_n        (rst_n),
        .rst_uart_n   (rst_uart_n),
        .rxd          (rxd),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err)
    );

endmodule

//--- tests/uart_assertions.sv
`timescale 1ns/1ps

module uart_assertions (
    input logic clk_bus,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic tx_start,
    input logic tx_idle,
    input logic txd
);

    int failures = 0;

    ack_needs_req: assert property (@(posedge clk_bus) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin
            failures++;
            $error("ack rose without a request");
        end

    ack_falls_after_req: assert property (@(posedge clk_bus) disable iff (!rst_n)
        $fell(ack) |-> $past(!req))
        else begin
            failures++;
            $error("ack fell before req fell");
        end

    idle_line_high: assert property (@(posedge clk_bus) disable iff (!rst_n)
        tx_idle |-> txd)
        else begin
            failures++;
            $error("txd low while transmitter idle");
        end

    start_only_when_idle: assert property (@(posedge clk_bus) disable iff (!rst_n)
        tx_start |-> tx_idle)
        else begin
            failures++;
            $error("tx_start while transmitter busy");
        end

endmodule

// the bus lives in uart_regs, txd in uart_tx.
bind uart_regs uart_assertions regs_checks (
    .clk_bus  (clk_bus),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .tx_start (tx_start),
    .tx_idle  (tx_idle),
    .txd      (1'b1)
);

bind uart_tx uart_assertions tx_checks (
    .clk_bus  (clk_bus),
    .rst_n    (rst_n),
    .req      (1'b0),
    .ack      (1'b0),
    .tx_start (tx_start),
    .tx_idle  (tx_idle),
    .txd      (txd)
);

//--- tests/uart_tb.sv
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

    logic      clk_bus = 1'b1;
    logic      clk_uart = 1'b0;
    logic      rst_n;
    logic      rst_uart_n;
    logic      req;
    logic      we;
    reg_addr_t addr;
    bus_word_t wdata;
    bus_word_t rdata;
    logic      ack;
    logic      txd;
    logic      rxd;
    logic      rxd_drv;
    logic      loopback;

    logic [31:0]           rng_state;
    int                    cycle_count;
    int                    bytes_sent;
    int                    frames_seen;
    int                    frames_checked;
    byte_t                 exp_bytes[$];
    logic [FRAME_BITS-1:0] got_frames[$];
    logic                  got_steady[$];

    uart_top UUT (
        .clk_bus    (clk_bus),
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .rst_uart_n (rst_uart_n),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .ack        (ack),
        .txd        (txd),
        .rxd        (rxd)
    );

    assign rxd = loopback ? txd : rxd_drv;

    always #4 clk_bus = ~clk_bus;
    always #7 clk_uart = ~clk_uart;

    always @(posedge clk_bus) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= 40 * FRAME_BITS * BIT_CYCLES * 2) begin
            $display("timeout: run did not finish within %0d clk_bus cycles", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic byte_t next_random_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    // start 0, data lsb first, stop 1.
    function automatic logic [FRAME_BITS-1:0] frame_of(input byte_t b);
        logic [FRAME_BITS-1:0] f;
        f    = '0;
        f[0] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            f[i + 1] = b[i];
        end
        f[FRAME_BITS - 1] = 1'b1;
        return f;
    endfunction

    function automatic bus_word_t flag(input int pos);
        return bus_word_t'(1) << pos;
    endfunction

    function automatic bus_word_t rx_flags();
        return flag(STATUS_RX_FULL) | flag(STATUS_RX_OVERRUN) | flag(STATUS_FRAME_ERR);
    endfunction

    function automatic int assertion_failures();
        return UUT.u_regs.regs_checks.failures + UUT.u_tx.tx_checks.failures;
    endfunction

    task automatic fail_with(input string msg);
        $display("%0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // one full four-phase cycle.
    task automatic bus_access(input logic write, input reg_addr_t a, input bus_word_t d,
                              output bus_word_t q);
        @(posedge clk_bus);
        #1;
        we    = write;
        addr  = a;
        wdata = d;
        req   = 1'b1;
        do begin
            @(posedge clk_bus);
            #1;
        end while (!ack);
        q   = rdata;  // valid while ack is high.
        req = 1'b0;
        do begin
            @(posedge clk_bus);
            #1;
        end while (ack);
    endtask

    task automatic bus_write(input reg_addr_t a, input bus_word_t d);
        bus_word_t unused;
        bus_access(1'b1, a, d, unused);
    endtask

    task automatic bus_read(input reg_addr_t a, output bus_word_t q);
        bus_access(1'b0, a, '0, q);
    endtask

    task automatic send_byte(input byte_t b);
        exp_bytes.push_back(b);
        bytes_sent++;
        bus_write(ADDR_TXDATA, b);
    endtask

    task automatic wait_tx_drained();
        while (frames_checked != bytes_sent) begin
            @(posedge clk_bus);
        end
    endtask

    task automatic wait_status(input bus_word_t mask, output bus_word_t st);
        int polls;
        polls = 0;
        bus_read(ADDR_STATUS, st);
        while ((st & mask) != mask) begin
            polls++;
            if (polls > 2 * FRAME_BITS * BIT_CYCLES) begin
                fail_with("STATUS never showed the expected receive flags");
            end else begin
                bus_read(ADDR_STATUS, st);
            end
        end
    endtask

    task automatic drive_frame(input byte_t b, input logic stop_level);
        logic [FRAME_BITS-1:0] bits;
        bits = {stop_level, b, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(posedge clk_uart);
            #1;
            rxd_drv = bits[i];
            repeat (BIT_CYCLES - 1) @(posedge clk_uart);
        end
        @(posedge clk_uart);
        #1;
        rxd_drv = 1'b1;
        repeat (2 * BIT_CYCLES) @(posedge clk_uart);  // idle gap.
    endtask

    // every bit is sampled 8 times on the falling uart edge.
    initial begin : txd_monitor
        logic [FRAME_BITS-1:0] frame;
        logic                  level;
        logic                  steady;
        int                    bit_n;
        int                    pos;
        forever begin
            @(negedge clk_uart);
            if (rst_uart_n === 1'b1 && txd === 1'b0) begin
                frame  = '0;
                level  = 1'b0;
                steady = 1'b1;
                for (int s = 0; s < FRAME_BITS * BIT_CYCLES; s++) begin
                    if (s > 0) begin
                        @(negedge clk_uart);
                    end
                    bit_n = s / BIT_CYCLES;
                    pos   = s % BIT_CYCLES;
                    if (pos == 0) begin
                        level = txd;
                    end else if (txd !== level) begin
                        steady = 1'b0;
                    end
                    if (pos == BIT_CYCLES / 2) begin
                        frame[bit_n] = txd;  // mid-bit.
                    end
                end
                got_frames.push_back(frame);
                got_steady.push_back(steady);
                frames_seen++;
            end
        end
    end

    initial begin : frame_compare
        logic [FRAME_BITS-1:0] frame;
        logic                  steady;
        byte_t                 exp_byte;
        forever begin
            @(posedge clk_bus);
            if (got_frames.size() > 0) begin
                frame  = got_frames.pop_front();
                steady = got_steady.pop_front();
                if (exp_bytes.size() == 0) begin
                    fail_with("a frame appeared on txd with no byte written to TXDATA");
                end else begin
                    exp_byte = exp_bytes.pop_front();
                    check_equal(steady, 1'b1, "txd bit not held for BIT_CYCLES");
                    check_equal(frame, frame_of(exp_byte), "txd frame");
                    frames_checked++;
                end
            end
        end
    end

    initial begin : main_sequence
        bus_word_t st;
        bus_word_t d;
        byte_t     b;
        byte_t     bad_byte;
        byte_t     good_byte;
        int        base;
        rng_state  = 32'h8b016002;
        rst_n      = 1'b0;
        rst_uart_n = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        rxd_drv    = 1'b1;
        loopback   = 1'b0;
        repeat (3) @(posedge clk_bus);
        #1;
        rst_n      = 1'b1;
        rst_uart_n = 1'b1;

        check_equal(txd, 1'b1, "txd after reset");
        check_equal(ack, 1'b0, "ack after reset");
        bus_read(ADDR_STATUS, st);
        check_equal(st, flag(STATUS_TX_IDLE), "STATUS after reset");

        repeat (20) begin
            b = next_random_byte();
            send_byte(b);
        end
        wait_tx_drained();

        // second write is held off by the busy transmitter.
        base = frames_seen;
        send_byte(next_random_byte());
        send_byte(next_random_byte());
        check_equal(frames_seen, base + 1, "frames done when second TXDATA write was acked");
        wait_tx_drained();

        loopback = 1'b1;
        repeat (10) begin
            b = next_random_byte();
            send_byte(b);
            wait_status(flag(STATUS_RX_FULL), st);
            check_equal(st & rx_flags(), flag(STATUS_RX_FULL), "STATUS after loopback frame");
            bus_read(ADDR_RXDATA, d);
            check_equal(d, b, "RXDATA after loopback frame");
            bus_read(ADDR_STATUS, st);
            check_equal(st[STATUS_RX_FULL], 1'b0, "rx_full after RXDATA read");
        end
        wait_tx_drained();
        loopback = 1'b0;

        bad_byte  = next_random_byte();
        good_byte = next_random_byte();
        drive_frame(bad_byte, 1'b0);
        wait_status(flag(STATUS_RX_FULL), st);
        check_equal(st & rx_flags(), flag(STATUS_RX_FULL) | flag(STATUS_FRAME_ERR),
                    "STATUS after frame with bad stop bit");
        drive_frame(good_byte, 1'b1);
        wait_status(flag(STATUS_RX_OVERRUN), st);
        check_equal(st & rx_flags(), rx_flags(), "STATUS after overrun");
        bus_read(ADDR_RXDATA, d);
        check_equal(d, good_byte, "RXDATA after overrun");
        bus_write(ADDR_STATUS, flag(STATUS_RX_OVERRUN) | flag(STATUS_FRAME_ERR));
        bus_read(ADDR_STATUS, st);
        check_equal(st, flag(STATUS_TX_IDLE), "STATUS after clearing sticky bits");

        wait_tx_drained();
        check_equal(exp_bytes.size(), 0, "bytes written without a frame on txd");
        if (assertion_failures() != 0) begin
            $display("%0d assertion failures in the bound checkers", assertion_failures());
            $display("ERRORS FOUND");
            $fatal(1, "assertion failures");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- tb.f
design/uart_pkg.sv
design/flag_sync.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_top.sv
tests/uart_assertions.sv
tests/uart_tb.sv

//--- Bender.yml
package:
  name: uart

sources:
  - design/uart_pkg.sv
  - design/flag_sync.sv
  - design/uart_tx.sv
  - design/uart_rx.sv
  - design/uart_regs.sv
  - design/uart_top.sv
  - target: test
    files:
      - tests/uart_assertions.sv
      - tests/uart_tb.sv
